//--- Bender.yml
package:
  name: dot_product

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dot_product_pkg.sv
      - verilog/product_stage.sv
      - verilog/pair_sum_stage.sv
      - verilog/dot_product_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/tb_clock_gen.sv
      - verification/dot_product_properties.sv
      - verification/dot_product_tb.sv

//--- project.f
+incdir+verilog
verilog/dot_product_pkg.sv
verilog/product_stage.sv
verilog/pair_sum_stage.sv
verilog/dot_product_top.sv
verification/tb_clock_gen.sv
verification/dot_product_properties.sv
verification/dot_product_tb.sv

//--- verification/dot_product_properties.sv
`timescale 1ns/1ns
`default_nettype none

`include "dot_product_macros.svh"

module dot_product_properties (
    input logic clk,
    input logic rst_n,
    input logic compute,
    input logic in_last,
    input logic out_valid,
    input logic out_last
);

    // ############################################################
    // Strobe timing
    // ############################################################

    // Two sampled reset edges, so the async clear has settled
    property p_reset_quiet;
        @(posedge clk) (!rst_n ##1 !rst_n) |-> !out_valid;
    endproperty

    // Fixed latency, every accepted pair and every gap
    property p_valid_latency;
        @(posedge clk) disable iff (!rst_n)
            out_valid == $past(compute, `DP_LATENCY);
    endproperty

    property p_last_needs_valid;
        @(posedge clk) disable iff (!rst_n)
            out_last |-> out_valid;
    endproperty

    // Last travels with its own pair
    property p_last_latency;
        @(posedge clk) disable iff (!rst_n)
            out_valid |-> (out_last == $past(in_last, `DP_LATENCY));
    endproperty

    // ############################################################
    // Assertions
    // ############################################################

    a_reset_quiet: assert property (p_reset_quiet)
        else $error("out_valid high during reset");

    a_valid_latency: assert property (p_valid_latency)
        else $error("out_valid does not follow compute by the pipeline latency");

    a_last_needs_valid: assert property (p_last_needs_valid)
        else $error("out_last high without out_valid");

    a_last_latency: assert property (p_last_latency)
        else $error("out_last does not match in_last of its pair");

endmodule

`default_nettype wire

//--- verification/dot_product_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "dot_product_macros.svh"

module dot_product_tb;

    localparam int TABLE_LEN      = 48;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_MARGIN = 20;
    localparam int TIMEOUT_CYCLES = TABLE_LEN + `DP_LATENCY + RESET_CYCLES + TIMEOUT_MARGIN;

    logic                       clk;
    logic                       rst_n;
    logic                       compute;
    dot_product_pkg::vec_t      vec_a;
    dot_product_pkg::vec_t      vec_b;
    logic                       in_last;
    dot_product_pkg::result_t   dot_product;
    logic                       out_valid;
    logic                       out_last;

    // Stimulus table, one row per cycle
    dot_product_pkg::vec_t      tab_a       [TABLE_LEN];
    dot_product_pkg::vec_t      tab_b       [TABLE_LEN];
    logic                       tab_last    [TABLE_LEN];
    logic                       tab_compute [TABLE_LEN];
    dot_product_pkg::result_t   tab_exp     [TABLE_LEN];

    // Pairs in flight, in acceptance order
    dot_product_pkg::result_t   exp_sum_q   [$];
    logic                       exp_last_q  [$];
    int                         exp_cycle_q [$];

    integer                     seed;
    int                         cycle_count    = 0;
    int                         error_count    = 0;
    int                         check_count    = 0;
    int                         accepted_count = 0;
    int                         results_seen   = 0;

    // Monitor state
    dot_product_pkg::result_t   held_sum = '0;
    dot_product_pkg::result_t   mon_sum;
    logic                       mon_last;
    int                         mon_cycle;

    // ############################################################
    // Clock, DUT and properties
    // ############################################################

    tb_clock_gen #(
        .CLK_PERIOD   (20),
        .RESET_CYCLES (RESET_CYCLES)
    ) clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    dot_product_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .compute     (compute),
        .vec_a       (vec_a),
        .vec_b       (vec_b),
        .in_last     (in_last),
        .dot_product (dot_product),
        .out_valid   (out_valid),
        .out_last    (out_last)
    );

    bind dot_product_top dot_product_properties props_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .compute   (compute),
        .in_last   (in_last),
        .out_valid (out_valid),
        .out_last  (out_last)
    );

    // ############################################################
    // Model and helpers
    // ############################################################

    // Sum over lanes of a[i] * b[i]
    function automatic dot_product_pkg::result_t dot_model(
        input dot_product_pkg::vec_t a,
        input dot_product_pkg::vec_t b
    );
        int acc;
        acc = 0;
        for (int lane = 0; lane < `DP_LANES; lane++) begin
            acc += int'(a[lane]) * int'(b[lane]);
        end
        return dot_product_pkg::result_t'(acc);
    endfunction

    // Same element in every lane
    function automatic dot_product_pkg::vec_t splat_vec(input dot_product_pkg::elem_t value);
        dot_product_pkg::vec_t v;
        for (int lane = 0; lane < `DP_LANES; lane++) begin
            v[lane] = value;
        end
        return v;
    endfunction

    // Lane i holds i + 1
    function automatic dot_product_pkg::vec_t ramp_vec();
        dot_product_pkg::vec_t v;
        for (int lane = 0; lane < `DP_LANES; lane++) begin
            v[lane] = 8'(lane + 1);
        end
        return v;
    endfunction

    task automatic check_value(
        input string       name,
        input logic [31:0] actual,
        input logic [31:0] expected
    );
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h at cycle %0d",
                     name, actual, expected, cycle_count);
        end
    endtask

    task automatic set_row(
        input int                       row,
        input dot_product_pkg::vec_t    a,
        input dot_product_pkg::vec_t    b,
        input logic                     last,
        input logic                     accept,
        input dot_product_pkg::result_t exp_sum
    );
        tab_a[row]       = a;
        tab_b[row]       = b;
        tab_last[row]    = last;
        tab_compute[row] = accept;
        tab_exp[row]     = exp_sum;
    endtask

    task automatic build_table();
        int row;
        dot_product_pkg::vec_t lone_a;
        dot_product_pkg::vec_t edge_a;
        dot_product_pkg::vec_t edge_b;
        lone_a    = '0;
        lone_a[3] = 8'd200;
        edge_a    = '0;
        edge_a[0] = 8'd255;
        edge_a[7] = 8'd1;
        edge_b    = '0;
        edge_b[0] = 8'd1;
        edge_b[7] = 8'd255;

        // All zeros
        set_row(0, '0, '0, 1'b0, 1'b1, 19'd0);
        // One lane only, lane 3
        set_row(1, lone_a, splat_vec(8'd150), 1'b0, 1'b1, 19'd30000);
        // Largest operands, still fits in 19 bits
        set_row(2, splat_vec(8'd255), splat_vec(8'd255), 1'b1, 1'b1, 19'd520200);
        // Two gap cycles, data and last must be ignored
        set_row(3, splat_vec(8'd9), splat_vec(8'd9), 1'b1, 1'b0, 19'd0);
        set_row(4, splat_vec(8'd3), splat_vec(8'd5), 1'b0, 1'b0, 19'd0);
        // Back-to-back burst, last on the final pair
        set_row(5, splat_vec(8'd1), ramp_vec(), 1'b0, 1'b1, 19'd36);
        set_row(6, ramp_vec(), splat_vec(8'd2), 1'b0, 1'b1, 19'd72);
        set_row(7, splat_vec(8'd10), splat_vec(8'd10), 1'b0, 1'b1, 19'd800);
        set_row(8, edge_a, edge_b, 1'b1, 1'b1, 19'd510);
        // Single gap, then a lone pair
        set_row(9, splat_vec(8'd7), splat_vec(8'd7), 1'b0, 1'b0, 19'd0);
        set_row(10, splat_vec(8'd2), splat_vec(8'd3), 1'b1, 1'b1, 19'd48);

        // Random tail, about one gap in four
        for (row = 11; row < TABLE_LEN; row++) begin
            for (int lane = 0; lane < `DP_LANES; lane++) begin
                tab_a[row][lane] = 8'($random(seed));
                tab_b[row][lane] = 8'($random(seed));
            end
            tab_compute[row] = (($random(seed) & 3) != 0);
            tab_last[row]    = (($random(seed) & 7) == 0);
            tab_exp[row]     = dot_model(tab_a[row], tab_b[row]);
        end
    endtask

    // Drive one row on the falling edge, note it if it will be accepted
    task automatic apply_row(input int row);
        @(negedge clk);
        compute = tab_compute[row];
        vec_a   = tab_a[row];
        vec_b   = tab_b[row];
        in_last = tab_last[row];
        if (tab_compute[row]) begin
            exp_sum_q.push_back(tab_exp[row]);
            exp_last_q.push_back(tab_last[row]);
            // Accepted on the next rising edge
            exp_cycle_q.push_back(cycle_count + 1);
            accepted_count++;
        end
    endtask

    task automatic drive_idle();
        @(negedge clk);
        compute = 1'b0;
        in_last = 1'b0;
    endtask

    // ############################################################
    // Cycle counter and timeout
    // ############################################################

    always @(posedge clk) begin : watchdog
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles, %0d results pending",
                     TIMEOUT_CYCLES, exp_sum_q.size());
            $display("Checks failed");
            $finish;
        end
    end

    // ############################################################
    // Output monitor
    // ############################################################

    // Outputs are registered, stable on the falling edge
    always @(negedge clk) begin : monitor
        if (rst_n === 1'b1) begin
            if (out_valid === 1'b1) begin
                // Every strobe counts, expected or not
                results_seen++;
                if (exp_sum_q.size() == 0) begin
                    error_count++;
                    $display("Error: result seen at cycle %0d with no accepted pair pending",
                             cycle_count);
                end else begin
                    mon_sum   = exp_sum_q.pop_front();
                    mon_last  = exp_last_q.pop_front();
                    mon_cycle = exp_cycle_q.pop_front();
                    check_value("dot_product", dot_product, mon_sum);
                    check_value("out_last", out_last, mon_last);
                    // Result is taken by the next rising edge
                    check_value("latency", cycle_count + 1 - mon_cycle, `DP_LATENCY);
                    held_sum = mon_sum;
                end
            end else begin
                // Gap cycle, result holds and last stays low
                check_value("out_last", out_last, 1'b0);
                check_value("dot_product", dot_product, held_sum);
            end
        end
    end

    // ############################################################
    // Main sequence
    // ############################################################

    initial begin : main
        int row;
        compute = 1'b0;
        in_last = 1'b0;
        vec_a   = '0;
        vec_b   = '0;
        seed    = 32'h37e140cb;
        build_table();

        wait (rst_n === 1'b1);
        @(negedge clk);
        // Clean state out of reset
        check_value("dot_product", dot_product, 0);
        check_value("out_valid", out_valid, 1'b0);
        check_value("out_last", out_last, 1'b0);
        repeat (2) drive_idle();

        for (row = 0; row < TABLE_LEN; row++) begin
            apply_row(row);
        end
        drive_idle();

        // Drain the pipeline, then watch for stray results
        while (exp_sum_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        check_value("result_count", results_seen, accepted_count);

        $display("Summary: %0d checks, %0d errors, %0d pairs accepted, %0d results",
                 check_count, error_count, accepted_count, results_seen);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int CLK_PERIOD   = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    // Free-running clock, low at time zero
    initial begin : proc_clk
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Reset released on a falling edge, away from the sampling edge
    initial begin : proc_rst
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- verilog/dot_product_macros.svh
`ifndef DOT_PRODUCT_MACROS_SVH
`define DOT_PRODUCT_MACROS_SVH

// ############################################################
// Dot-product engine dimensions
// ############################################################

// Lanes per vector, a power of two for the pair-sum tree
`define DP_LANES 8

// Unsigned element width
`define DP_ELEM_W 8

// Full-precision lane product
`define DP_PROD_W (2 * `DP_ELEM_W)

// One carry bit per tree level, three levels for eight lanes
`define DP_RESULT_W (`DP_PROD_W + 3)

// Accepting edge to registered result
`define DP_LATENCY 4

`endif

//--- verilog/dot_product_pkg.sv
`default_nettype none

`include "dot_product_macros.svh"

package dot_product_pkg;

    // One unsigned vector element
    typedef logic [`DP_ELEM_W-1:0] elem_t;

    // Lane 0 sits at the low end
    typedef elem_t [`DP_LANES-1:0] vec_t;

    // Product of two elements
    typedef logic [`DP_PROD_W-1:0] product_t;

    // Sum of all lane products
    typedef logic [`DP_RESULT_W-1:0] result_t;

endpackage

`default_nettype wire

//--- verilog/dot_product_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "dot_product_macros.svh"

module dot_product_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       compute,
    input  dot_product_pkg::vec_t      vec_a,
    input  dot_product_pkg::vec_t      vec_b,
    input  logic                       in_last,
    output dot_product_pkg::result_t   dot_product,
    output logic                       out_valid,
    output logic                       out_last
);

    // ############################################################
    // Inter-stage buses
    // ############################################################

    // 8 products of 16 bits
    logic [`DP_LANES*`DP_PROD_W-1:0]             prod_bus;
    logic                                        prod_valid;
    logic                                        prod_last;

    // 4 partial sums of 17 bits
    logic [(`DP_LANES/2)*(`DP_PROD_W+1)-1:0]     l1_bus;
    logic                                        l1_valid;
    logic                                        l1_last;

    // 2 partial sums of 18 bits
    logic [(`DP_LANES/4)*(`DP_PROD_W+2)-1:0]     l2_bus;
    logic                                        l2_valid;
    logic                                        l2_last;

    // ############################################################
    // Pipeline, one register per stage
    // ############################################################

    product_stage prod_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .compute    (compute),
        .vec_a      (vec_a),
        .vec_b      (vec_b),
        .in_last    (in_last),
        .products   (prod_bus),
        .prod_valid (prod_valid),
        .prod_last  (prod_last)
    );

    pair_sum_stage #(.N_IN(`DP_LANES), .IN_W(`DP_PROD_W)) sum_l1_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (prod_valid),
        .in_last   (prod_last),
        .operands  (prod_bus),
        .sums      (l1_bus),
        .out_valid (l1_valid),
        .out_last  (l1_last)
    );

    pair_sum_stage #(.N_IN(`DP_LANES/2), .IN_W(`DP_PROD_W+1)) sum_l2_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (l1_valid),
        .in_last   (l1_last),
        .operands  (l1_bus),
        .sums      (l2_bus),
        .out_valid (l2_valid),
        .out_last  (l2_last)
    );

    // Final adder, its single 19-bit sum is the result
    pair_sum_stage #(.N_IN(`DP_LANES/4), .IN_W(`DP_PROD_W+2)) sum_l3_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (l2_valid),
        .in_last   (l2_last),
        .operands  (l2_bus),
        .sums      (dot_product),
        .out_valid (out_valid),
        .out_last  (out_last)
    );

endmodule

`default_nettype wire

//--- verilog/pair_sum_stage.sv
`timescale 1ns/1ns
`default_nettype none

module pair_sum_stage #(
    parameter int N_IN = 8,
    parameter int IN_W = 16
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_valid,
    input  logic                                in_last,
    input  logic [N_IN*IN_W-1:0]                operands,
    output logic [(N_IN/2)*(IN_W+1)-1:0]        sums,
    output logic                                out_valid,
    output logic                                out_last
);

    localparam int N_OUT = N_IN / 2;
    localparam int OUT_W = IN_W + 1;

    // Odd input counts would drop an operand
    generate
        if ((N_IN % 2) != 0) begin : gen_bad_n_in
            $error("pair_sum_stage needs an even N_IN");
        end
    endgenerate

    // ############################################################
    // Adjacent pair adders
    // ############################################################

    logic [N_OUT*OUT_W-1:0] sums_next;

    genvar k;
    generate
        for (k = 0; k < N_OUT; k++) begin : gen_pair_add
            // Zero-extend so the carry lands in the extra bit
            assign sums_next[k*OUT_W +: OUT_W] =
                {1'b0, operands[(2*k)*IN_W +: IN_W]} +
                {1'b0, operands[(2*k+1)*IN_W +: IN_W]};
        end
    endgenerate

    // ############################################################
    // Stage register
    // ############################################################

    always_ff @(posedge clk or negedge rst_n) begin : proc_stage
        if (!rst_n) begin
            sums      <= '0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else if (in_valid) begin
            sums      <= sums_next;
            out_valid <= 1'b1;
            out_last  <= in_last;
        end else begin
            // Sums hold their last valid value through gaps
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/product_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "dot_product_macros.svh"

module product_stage (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              compute,
    input  dot_product_pkg::vec_t             vec_a,
    input  dot_product_pkg::vec_t             vec_b,
    input  logic                              in_last,
    output logic [`DP_LANES*`DP_PROD_W-1:0]   products,
    output logic                              prod_valid,
    output logic                              prod_last
);

    // ############################################################
    // Lane-wise multiply
    // ############################################################

    dot_product_pkg::product_t [`DP_LANES-1:0] lane_prod;

    genvar lane;
    generate
        for (lane = 0; lane < `DP_LANES; lane++) begin : gen_lane_mul
            // Product width set by the 16-bit target
            assign lane_prod[lane] = vec_a[lane] * vec_b[lane];
        end
    endgenerate

    // Products load only on an accepting edge, hold otherwise
    always_ff @(posedge clk) begin : proc_products
        if (compute) begin
            products <= lane_prod;
        end
    end

    // ############################################################
    // Valid and last tracking
    // ############################################################

    always_ff @(posedge clk or negedge rst_n) begin : proc_ctrl
        if (!rst_n) begin
            prod_valid <= 1'b0;
            prod_last  <= 1'b0;
        end else begin
            prod_valid <= compute;
            // Last only counts alongside an accepted pair
            prod_last  <= compute & in_last;
        end
    end

endmodule

`default_nettype wire
